/* logic/ex_pkg.sv */
package ex_pkg;

    localparam int XLEN         = 64;
    localparam int MULDIV_STEPS = XLEN;  // one product or quotient bit per step

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [31:0]     half_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [1:0]      mem_size_t;

    // access sizes
    localparam mem_size_t MEM_BYTE   = 2'd0;
    localparam mem_size_t MEM_HALF   = 2'd1;
    localparam mem_size_t MEM_WORD   = 2'd2;
    localparam mem_size_t MEM_DOUBLE = 2'd3;

    // major opcodes
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;

    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // branch conditions in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_REG, ALU_IMM, LUI, AUIPC, BRANCH, JAL,
        JALR, LOAD, STORE, MULDIV, NONE
    } op_class_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_e;

    // same order as funct3 of the M extension
    typedef enum logic [2:0] {
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU
    } muldiv_op_e;

endpackage

/* logic/ex_decode.sv */
`timescale 1ns/1ns

module ex_decode (
    input  ex_pkg::instr_t     instr,
    output ex_pkg::op_class_e  op_class,
    output ex_pkg::alu_op_e    alu_op,
    output logic               is_word,
    output ex_pkg::muldiv_op_e md_op
);
    import ex_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       reg_form;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign reg_form = (opcode == OPC_OP) || (opcode == OPC_OP_32);
    assign is_word  = (opcode == OPC_OP_32) || (opcode == OPC_OP_IMM_32);
    assign md_op    = muldiv_op_e'(funct3);

    always_comb begin
        case (opcode)
            OPC_OP, OPC_OP_32: begin
                op_class = (funct7 == FUNCT7_MULDIV) ? MULDIV : ALU_REG;
            end
            OPC_OP_IMM, OPC_OP_IMM_32: op_class = ALU_IMM;
            OPC_LUI:    op_class = LUI;
            OPC_AUIPC:  op_class = AUIPC;
            OPC_BRANCH: op_class = BRANCH;
            OPC_JAL:    op_class = JAL;
            OPC_JALR:   op_class = JALR;
            OPC_LOAD:   op_class = LOAD;
            OPC_STORE:  op_class = STORE;
            default:    op_class = NONE;
        endcase
    end

    // loads, stores and the rest only need an add
    always_comb begin
        alu_op = ADD;
        if (op_class == ALU_REG || op_class == ALU_IMM) begin
            case (funct3)
                3'b000:  alu_op = (reg_form && instr[30]) ? SUB : ADD;
                3'b001:  alu_op = SLL;
                3'b010:  alu_op = SLT;
                3'b011:  alu_op = SLTU;
                3'b100:  alu_op = XOR;
                3'b101:  alu_op = instr[30] ? SRA : SRL;  // srai keeps bit 30 too
                3'b110:  alu_op = OR;
                default: alu_op = AND;
            endcase
        end
    end

endmodule

/* logic/ex_alu.sv */
`timescale 1ns/1ns

module ex_alu (
    input  ex_pkg::alu_op_e alu_op,
    input  logic            is_word,
    input  ex_pkg::word_t   a,
    input  ex_pkg::word_t   b,
    output ex_pkg::word_t   y
);
    import ex_pkg::*;

    logic [5:0] shamt;
    logic [4:0] shamt_w;
    half_t      a_w;
    half_t      b_w;
    word_t      y_full;
    half_t      y_half;

    assign shamt   = b[5:0];
    assign shamt_w = b[4:0];
    assign a_w     = a[31:0];
    assign b_w     = b[31:0];

    always_comb begin
        case (alu_op)
            ADD:     y_full = a + b;
            SUB:     y_full = a - b;
            SLL:     y_full = a << shamt;
            SLT:     y_full = word_t'($signed(a) < $signed(b));
            SLTU:    y_full = word_t'(a < b);
            XOR:     y_full = a ^ b;
            SRL:     y_full = a >> shamt;
            SRA:     y_full = $signed(a) >>> shamt;
            OR:      y_full = a | b;
            default: y_full = a & b;
        endcase
    end

    // 32-bit forms, only arithmetic and shifts differ from the low half
    always_comb begin
        case (alu_op)
            ADD:     y_half = a_w + b_w;
            SUB:     y_half = a_w - b_w;
            SLL:     y_half = a_w << shamt_w;
            SRL:     y_half = a_w >> shamt_w;
            SRA:     y_half = $signed(a_w) >>> shamt_w;
            default: y_half = y_full[31:0];
        endcase
    end

    assign y = is_word ? {{32{y_half[31]}}, y_half} : y_full;

endmodule

/* logic/ex_branch.sv */
`timescale 1ns/1ns

module ex_branch (
    input  ex_pkg::op_class_e op_class,
    input  logic [2:0]        funct3,
    input  ex_pkg::addr_t     pc,
    input  ex_pkg::word_t     imm,
    input  ex_pkg::word_t     rs1,
    input  ex_pkg::word_t     rs2,
    output logic              taken,
    output ex_pkg::addr_t     target,
    output ex_pkg::word_t     link
);
    import ex_pkg::*;

    logic  cond;
    addr_t jalr_sum;

    always_comb begin
        case (funct3)
            F3_BEQ:  cond = (rs1 == rs2);
            F3_BNE:  cond = (rs1 != rs2);
            F3_BLT:  cond = ($signed(rs1) < $signed(rs2));
            F3_BGE:  cond = ($signed(rs1) >= $signed(rs2));
            F3_BLTU: cond = (rs1 < rs2);
            F3_BGEU: cond = (rs1 >= rs2);
            default: cond = 1'b0;  // reserved encodings
        endcase
    end

    assign taken = ((op_class == BRANCH) && cond) || (op_class == JAL) || (op_class == JALR);

    assign jalr_sum = rs1 + imm;
    // pc relative for everything but jalr, also serves auipc
    assign target   = (op_class == JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;
    assign link     = pc + word_t'(4);

endmodule

/* logic/ex_muldiv.sv */
`timescale 1ns/1ns

module ex_muldiv (
    input  logic               clk,
    input  logic               reset,
    input  logic               block,
    input  logic               start,
    input  ex_pkg::muldiv_op_e md_op,
    input  logic               is_word,
    input  ex_pkg::word_t      a,
    input  ex_pkg::word_t      b,
    output logic               busy,
    output logic               done,
    output ex_pkg::word_t      result
);
    import ex_pkg::*;

    typedef enum logic [1:0] {IDLE, RUN, FINISH} state_e;

    localparam int               CNT_W    = $clog2(MULDIV_STEPS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MULDIV_STEPS - 1);

    state_e            state;
    logic [CNT_W-1:0]  count;
    muldiv_op_e        op_q;
    logic              word_q;
    logic              neg_q;      // result needs negating
    logic [XLEN:0]     hi;         // partial product high or partial remainder
    word_t             lo;         // multiplier or dividend, shifts into low product or quotient
    word_t             mag_b;      // multiplicand or divisor magnitude
    word_t             a_ext;
    word_t             b_ext;
    logic              a_neg;
    logic              b_neg;
    logic              b_zero;
    logic              neg_start;
    logic [XLEN:0]     mul_sum;
    logic [XLEN:0]     div_shift;
    logic [XLEN:0]     div_diff;
    logic [2*XLEN-1:0] prod_raw;
    logic [2*XLEN-1:0] prod;
    word_t             div_val;
    word_t             final_val;

    assign busy = (state != IDLE);

    always_comb begin
        // w forms work on extended low halves
        if (is_word && (md_op == DIVU || md_op == REMU)) begin
            a_ext = {32'b0, a[31:0]};
            b_ext = {32'b0, b[31:0]};
        end else if (is_word) begin
            a_ext = {{32{a[31]}}, a[31:0]};
            b_ext = {{32{b[31]}}, b[31:0]};
        end else begin
            a_ext = a;
            b_ext = b;
        end
        a_neg  = (md_op inside {MULH, MULHSU, DIV, REM}) && a_ext[XLEN-1];
        b_neg  = (md_op inside {MULH, DIV, REM}) && b_ext[XLEN-1];
        b_zero = (b_ext == '0);
        case (md_op)
            REM, REMU: neg_start = a_neg;
            DIV, DIVU: neg_start = (a_neg ^ b_neg) && !b_zero;  // x/0 stays all ones
            default:   neg_start = a_neg ^ b_neg;
        endcase
    end

    // one step of each algorithm
    assign mul_sum   = {1'b0, hi[XLEN-1:0]} + (lo[0] ? {1'b0, mag_b} : '0);
    assign div_shift = {hi[XLEN-1:0], lo[XLEN-1]};
    assign div_diff  = div_shift - {1'b0, mag_b};

    // overflow case falls out of the magnitudes, -(2^63) negates to itself
    assign prod_raw = {hi[XLEN-1:0], lo};
    assign prod     = neg_q ? -prod_raw : prod_raw;
    assign div_val  = (op_q == REM || op_q == REMU) ? hi[XLEN-1:0] : lo;

    always_comb begin
        case (op_q)
            MUL:                 final_val = prod[XLEN-1:0];
            MULH, MULHSU, MULHU: final_val = prod[2*XLEN-1:XLEN];
            default:             final_val = neg_q ? -div_val : div_val;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            count <= '0;
            done  <= 1'b0;
        end else if (!block) begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        count <= '0;
                    end
                end
                RUN: begin
                    count <= count + 1'b1;
                    if (count == CNT_LAST) begin
                        state <= FINISH;
                    end
                end
                default: begin
                    state <= IDLE;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            if (state == IDLE && start) begin
                op_q   <= md_op;
                word_q <= is_word;
                neg_q  <= neg_start;
                hi     <= '0;
                lo     <= a_neg ? -a_ext : a_ext;
                mag_b  <= b_neg ? -b_ext : b_ext;
            end else if (state == RUN && op_q[2]) begin
                // restoring divide, keep the shifted remainder on borrow
                hi <= div_diff[XLEN] ? div_shift : div_diff;
                lo <= {lo[XLEN-2:0], !div_diff[XLEN]};
            end else if (state == RUN) begin
                hi <= {1'b0, mul_sum[XLEN:1]};
                lo <= {mul_sum[0], lo[XLEN-1:1]};
            end else if (state == FINISH) begin
                result <= word_q ? {{32{final_val[31]}}, final_val[31:0]} : final_val;
            end
        end
    end

    // a new operation must not be started while the finished one is reported
    done_not_with_start: assert property (@(posedge clk) disable iff (reset)
        done |-> !start);

endmodule

/* logic/ex_stage.sv */
`timescale 1ns/1ns

module ex_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              block,
    input  logic              id_finish,
    input  ex_pkg::addr_t     pc_in,
    input  ex_pkg::instr_t    instr_in,
    input  ex_pkg::word_t     imm,
    input  ex_pkg::word_t     rs1_data,
    input  ex_pkg::word_t     rs2_data,
    input  ex_pkg::reg_addr_t rd_in,
    input  logic              reg_write_in,
    input  logic              mem_read_in,
    input  logic              mem_write_in,
    input  ex_pkg::mem_size_t mem_size_in,
    output logic              ex_finish,
    output logic              valid,
    output ex_pkg::word_t     result,
    output ex_pkg::addr_t     pc_out,
    output ex_pkg::instr_t    instr_out,
    output ex_pkg::reg_addr_t rd_out,
    output logic              reg_write_out,
    output logic              mem_read_out,
    output logic              mem_write_out,
    output ex_pkg::mem_size_t mem_size_out,
    output logic              branch_out,
    output ex_pkg::addr_t     branch_target_out,
    output logic              muldiv_busy,
    output logic              misalign_valid,
    output ex_pkg::addr_t     misalign_addr,
    output logic              misalign_store
);
    import ex_pkg::*;

    op_class_e  op_class;
    alu_op_e    alu_op;
    logic       is_word;
    muldiv_op_e md_op;
    word_t      alu_b;
    word_t      alu_y;
    word_t      link;
    word_t      md_result;
    word_t      ex_value;
    addr_t      br_target;
    logic       br_taken;
    logic       accept;
    logic       alu_finish;   // single-cycle instruction done this edge
    logic       md_start;
    logic       md_busy;
    logic       md_done;
    logic       misaligned;
    logic       any_finish;

    // context of the instruction in the multiplier/divider
    addr_t      hold_pc;
    instr_t     hold_instr;
    reg_addr_t  hold_rd;
    logic       hold_reg_write;
    logic       hold_mem_read;
    logic       hold_mem_write;
    mem_size_t  hold_mem_size;

    ex_decode u_decode (.instr(instr_in), .op_class, .alu_op, .is_word, .md_op);

    assign alu_b = (op_class == ALU_REG) ? rs2_data : imm;

    ex_alu u_alu (.alu_op, .is_word, .a(rs1_data), .b(alu_b), .y(alu_y));

    ex_branch u_branch (
        .op_class, .funct3(instr_in[14:12]), .pc(pc_in), .imm,
        .rs1(rs1_data), .rs2(rs2_data), .taken(br_taken), .target(br_target), .link
    );

    ex_muldiv u_muldiv (
        .clk, .reset, .block, .start(md_start), .md_op, .is_word,
        .a(rs1_data), .b(rs2_data), .busy(md_busy), .done(md_done), .result(md_result)
    );

    assign accept      = id_finish && !block;
    assign md_start    = accept && (op_class == MULDIV);
    assign alu_finish  = accept && (op_class != MULDIV);
    assign any_finish  = alu_finish || md_done;
    assign muldiv_busy = md_busy || md_done;  // until the result has left

    always_comb begin
        case (op_class)
            LUI:       ex_value = imm;
            AUIPC:     ex_value = br_target;
            JAL, JALR: ex_value = link;
            default:   ex_value = alu_y;  // also the load/store address
        endcase
        case (mem_size_in)
            MEM_HALF:   misaligned = alu_y[0];
            MEM_WORD:   misaligned = |alu_y[1:0];
            MEM_DOUBLE: misaligned = |alu_y[2:0];
            default:    misaligned = 1'b0;  // byte
        endcase
        misaligned = misaligned && (mem_read_in || mem_write_in);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_finish      <= 1'b0;
            valid          <= 1'b0;
            branch_out     <= 1'b0;
            misalign_valid <= 1'b0;
        end else if (!block) begin
            ex_finish      <= any_finish;
            valid          <= md_done ? hold_reg_write && (hold_rd != '0)
                                      : alu_finish && reg_write_in && (rd_in != '0);
            branch_out     <= alu_finish && br_taken;
            misalign_valid <= alu_finish && misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            if (md_start) begin
                hold_pc        <= pc_in;
                hold_instr     <= instr_in;
                hold_rd        <= rd_in;
                hold_reg_write <= reg_write_in;
                hold_mem_read  <= mem_read_in;
                hold_mem_write <= mem_write_in;
                hold_mem_size  <= mem_size_in;
            end
            if (md_done) begin
                result        <= md_result;
                pc_out        <= hold_pc;
                instr_out     <= hold_instr;
                rd_out        <= hold_rd;
                reg_write_out <= hold_reg_write;
                mem_read_out  <= hold_mem_read;
                mem_write_out <= hold_mem_write;
                mem_size_out  <= hold_mem_size;
            end else if (alu_finish) begin
                result            <= misaligned ? '0 : ex_value;
                pc_out            <= pc_in;
                instr_out         <= instr_in;
                rd_out            <= rd_in;
                reg_write_out     <= reg_write_in;
                mem_read_out      <= mem_read_in;
                mem_write_out     <= mem_write_in;
                mem_size_out      <= mem_size_in;
                branch_target_out <= br_target;
                misalign_addr     <= alu_y;
                misalign_store    <= mem_write_in;
            end
        end
    end

    // decode must stall while an M instruction is outstanding
    no_issue_while_busy: assert property (@(posedge clk) disable iff (reset)
        muldiv_busy |-> !id_finish);

endmodule

/* verif/ex_stage_tb.sv */
`timescale 1ns/1ns

module ex_stage_tb;
    import ex_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CHECKS  = 3;  // cycles watched after reset

    logic      clk;
    logic      reset;
    logic      block;
    logic      id_finish;
    addr_t     pc_in;
    instr_t    instr_in;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rd_in;
    logic      reg_write_in;
    logic      mem_read_in;
    logic      mem_write_in;
    mem_size_t mem_size_in;
    logic      ex_finish;
    logic      valid;
    word_t     result;
    addr_t     pc_out;
    instr_t    instr_out;
    reg_addr_t rd_out;
    logic      reg_write_out;
    logic      mem_read_out;
    logic      mem_write_out;
    mem_size_t mem_size_out;
    logic      branch_out;
    addr_t     branch_target_out;
    logic      muldiv_busy;
    logic      misalign_valid;
    addr_t     misalign_addr;
    logic      misalign_store;

    string vectors[$];
    logic  loaded;

    ex_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error %s expected %h actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_vectors();
        int    fd;
        string line;
        fd = $fopen("verif/ex_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file verif/ex_input.txt");
            $display("TESTBENCH FAILED");
            $fatal(1, "no vectors");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin  // skip blanks and comments
                vectors.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input int idx, input string line);
        logic [63:0] f_pc, f_instr, f_imm, f_rs1, f_rs2, f_rd;
        logic [63:0] f_rw, f_mr, f_mw, f_size;
        logic [63:0] exp_result, exp_valid, exp_branch, exp_target, exp_mis;
        int          nblk;
        int          n;
        logic        is_m;
        logic        finished;
        string       tag;
        tag = $sformatf("vector %0d", idx);
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %d %h %h %h %h %h",
                    f_pc, f_instr, f_imm, f_rs1, f_rs2, f_rd, f_rw, f_mr, f_mw, f_size,
                    nblk, exp_result, exp_valid, exp_branch, exp_target, exp_mis);
        if (n != 16) begin
            $display("%s in the vector file has %0d fields instead of 16", tag, n);
            $display("TESTBENCH FAILED");
            $fatal(1, "bad vector line");
        end
        // M extension: OP or OP-32 with funct7 of one
        is_m = (f_instr[6:0] == OPC_OP || f_instr[6:0] == OPC_OP_32)
               && (f_instr[31:25] == FUNCT7_MULDIV);

        pc_in        = f_pc;
        instr_in     = f_instr[31:0];
        imm          = f_imm;
        rs1_data     = f_rs1;
        rs2_data     = f_rs2;
        rd_in        = f_rd[4:0];
        reg_write_in = f_rw[0];
        mem_read_in  = f_mr[0];
        mem_write_in = f_mw[0];
        mem_size_in  = f_size[1:0];
        id_finish    = 1'b1;
        block        = 1'b0;

        @(posedge clk);
        #1;
        id_finish = 1'b0;
        block     = (nblk != 0);
        if (is_m) begin
            pc_in        = '0;  // context must come from the stage's hold registers
            rd_in        = '0;
            instr_in     = '0;
            reg_write_in = 1'b0;
            check_value({tag, " ex_finish early"}, 0, ex_finish);
            check_value({tag, " muldiv_busy"}, 1, muldiv_busy);
        end else begin
            check_value({tag, " ex_finish after one cycle"}, 1, ex_finish);
        end
        finished = ex_finish;

        repeat (nblk) begin
            @(posedge clk);
            #1;
            if (is_m) begin
                check_value({tag, " muldiv_busy under block"}, 1, muldiv_busy);
                check_value({tag, " ex_finish under block"}, 0, ex_finish);
            end
        end
        block = 1'b0;

        while (!finished) begin
            @(posedge clk);
            #1;
            if (ex_finish) begin
                finished = 1'b1;
            end else begin
                check_value({tag, " muldiv_busy"}, 1, muldiv_busy);
            end
        end

        if (f_instr[6:0] != OPC_BRANCH) begin  // branch result carries nothing
            check_value({tag, " result"}, exp_result, result);
        end
        check_value({tag, " valid"}, exp_valid, valid);
        check_value({tag, " branch_out"}, exp_branch, branch_out);
        if (exp_branch[0]) begin
            check_value({tag, " branch_target_out"}, exp_target, branch_target_out);
        end
        check_value({tag, " misalign_valid"}, exp_mis, misalign_valid);
        if (exp_mis[0]) begin
            check_value({tag, " misalign_addr"}, f_rs1 + f_imm, misalign_addr);
            check_value({tag, " misalign_store"}, f_mw, misalign_store);
        end
        check_value({tag, " pc_out"}, f_pc, pc_out);
        check_value({tag, " instr_out"}, f_instr, instr_out);
        check_value({tag, " rd_out"}, f_rd, rd_out);
        check_value({tag, " reg_write_out"}, f_rw, reg_write_out);
        check_value({tag, " mem_read_out"}, f_mr, mem_read_out);
        check_value({tag, " mem_write_out"}, f_mw, mem_write_out);
        check_value({tag, " mem_size_out"}, f_size, mem_size_out);
        check_value({tag, " muldiv_busy at finish"}, 0, muldiv_busy);

        @(posedge clk);
        #1;
        check_value({tag, " ex_finish one cycle wide"}, 0, ex_finish);
    endtask

    // watchdog, sized from the number of vectors
    initial begin
        wait (loaded);
        #((vectors.size() + 1) * (MULDIV_STEPS + 20) * CLK_PERIOD);
        $display("timeout, the stage stopped answering with ex_finish");
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        reset        = 1'b1;
        block        = 1'b0;
        id_finish    = 1'b0;
        pc_in        = '0;
        instr_in     = '0;
        imm          = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        rd_in        = '0;
        reg_write_in = 1'b0;
        mem_read_in  = 1'b0;
        mem_write_in = 1'b0;
        mem_size_in  = '0;
        loaded       = 1'b0;
        load_vectors();
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (IDLE_CHECKS) begin
            @(posedge clk);
            #1;
            check_value("idle ex_finish", 0, ex_finish);
            check_value("idle valid", 0, valid);
            check_value("idle branch_out", 0, branch_out);
            check_value("idle misalign_valid", 0, misalign_valid);
            check_value("idle muldiv_busy", 0, muldiv_busy);
        end

        foreach (vectors[i]) begin
            run_vector(i, vectors[i]);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* verif/ex_input.txt */
# pc instr imm rs1 rs2 rd reg_write mem_read mem_write mem_size block_cycles(decimal)
# then expected: result valid branch_out branch_target_out misalign_valid (all hex)
1000 002081b3 0 5 7 3 1 0 0 0 0 c 1 0 0 0
1004 402081b3 0 5 7 3 1 0 0 0 2 fffffffffffffffe 1 0 0 0
1008 002091b3 0 1 43 0 1 0 0 0 0 8 0 0 0 0
100c 0020a1b3 0 ffffffffffffffff 1 3 1 0 0 0 0 1 1 0 0 0
1010 4020d1b3 0 8000000000000000 4 3 1 0 0 0 0 f800000000000000 1 0 0 0
1014 0020f1b3 0 ff00ff00 0ff00ff0 3 1 0 0 0 0 f000f00 1 0 0 0
1018 0010819b 1 7fffffff 0 3 1 0 0 0 0 ffffffff80000000 1 0 0 0
101c 4020d1bb 0 80000000 24 3 1 0 0 0 0 fffffffff8000000 1 0 0 0
1020 123451b7 12345000 0 0 3 1 0 0 0 0 12345000 1 0 0 0
2000 00001197 1000 0 0 3 1 0 0 0 0 3000 1 0 0 0
3000 00208063 40 5 5 0 0 0 0 0 0 0 0 1 3040 0
3004 00209063 40 5 5 0 0 0 0 0 0 0 0 0 0 0
3008 0020c063 fffffffffffffff0 ffffffffffffffff 1 0 0 0 0 0 0 0 0 1 2ff8 0
4000 000000ef 100 0 0 1 1 0 0 0 0 4004 1 1 4100 0
4100 000280e7 4 5001 0 1 1 0 0 0 0 4104 1 1 5004 0
5000 0000b183 8 1000 0 3 1 1 0 3 0 1008 1 0 0 0
5004 0000a183 6 1000 0 3 1 1 0 2 0 0 1 0 0 1
5008 00009183 0 1001 0 3 1 1 0 1 0 0 1 0 0 1
500c 00008183 3 1000 0 3 1 1 0 0 0 1003 1 0 0 0
5010 0020b023 4 1000 0 0 0 0 1 3 1 0 0 0 0 1
5014 0020a023 10 1000 0 0 0 0 1 2 0 1010 0 0 0 0
6000 022081b3 0 7 fffffffffffffffd 3 1 0 0 0 0 ffffffffffffffeb 1 0 0 0
6004 022091b3 0 8000000000000000 2 3 1 0 0 0 3 ffffffffffffffff 1 0 0 0
6008 0220a1b3 0 fffffffffffffffe ffffffffffffffff 3 1 0 0 0 0 fffffffffffffffe 1 0 0 0
600c 0220b1b3 0 ffffffffffffffff 2 3 1 0 0 0 0 1 1 0 0 0
6010 0220c1b3 0 ffffffffffffffec 3 3 1 0 0 0 2 fffffffffffffffa 1 0 0 0
6014 0220d1b3 0 1234 0 3 1 0 0 0 0 ffffffffffffffff 1 0 0 0
6018 0220e1b3 0 ffffffffffffffec 3 3 1 0 0 0 0 fffffffffffffffe 1 0 0 0
601c 0220f1b3 0 14 6 3 1 0 0 0 0 2 1 0 0 0
6020 0220c1b3 0 8000000000000000 ffffffffffffffff 3 1 0 0 0 0 8000000000000000 1 0 0 0
6024 0220e1b3 0 ffffffffffffffec 0 3 1 0 0 0 0 ffffffffffffffec 1 0 0 0
6028 022081bb 0 80000000 3 3 1 0 0 0 0 ffffffff80000000 1 0 0 0
602c 0220c1bb 0 12345678fffffff0 3 3 1 0 0 0 1 fffffffffffffffb 1 0 0 0

/* list.f */
logic/ex_pkg.sv
logic/ex_decode.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_muldiv.sv
logic/ex_stage.sv
verif/ex_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ex_stage_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vex_stage_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
fi
exit 1
